//--- verilog/firPkg.sv
package firPkg;

    localparam int osrFactor = 4;
    localparam int lookahead = 12;
    localparam int lookback = 12;
    localparam int tapCount = lookahead + lookback;
    localparam int lutSize = 6;
    localparam int lutCount = tapCount / lutSize;
    localparam int coefWidth = 16;
    localparam int partWidth = 19;
    localparam int sumWidth = 21;

    // coefAhead[lookahead-1] weighs the newest bit of a capture.
    localparam logic signed [coefWidth-1:0] coefAhead [lookahead] = '{
        16'sd9850, 16'sd9720, 16'sd9110, 16'sd7830,
        16'sd6020, 16'sd4010, 16'sd2140, 16'sd690,
        -16'sd156, -16'sd402, -16'sd310, -16'sd120
    };

    // coefBack[0] weighs the bit of age lookahead, the oldest comes last.
    localparam logic signed [coefWidth-1:0] coefBack [lookback] = '{
        16'sd9790, 16'sd9540, 16'sd8870, 16'sd7510,
        16'sd5660, 16'sd3700, 16'sd1930, 16'sd580,
        -16'sd190, -16'sd395, -16'sd290, -16'sd105
    };

    // entry m of table g sums the coefficients of window bits g*lutSize+j set in m.
    function automatic logic [lutCount-1:0][2**lutSize-1:0][partWidth-1:0] buildLut();
        logic [lutCount-1:0][2**lutSize-1:0][partWidth-1:0] tables;
        logic signed [partWidth-1:0] acc;
        int k;
        for (int g = 0; g < lutCount; g++) begin
            for (int m = 0; m < 2**lutSize; m++) begin
                acc = '0;
                for (int j = 0; j < lutSize; j++) begin
                    k = g * lutSize + j;
                    if (m[j]) begin
                        if (k < lookahead) begin
                            acc = acc + coefAhead[k];
                        end else begin
                            acc = acc + coefBack[k - lookahead];
                        end
                    end
                end
                tables[g][m] = acc;
            end
        end
        return tables;
    endfunction

    // one table per window group, fixed at elaboration.
    localparam logic [lutCount-1:0][2**lutSize-1:0][partWidth-1:0] lutTables = buildLut();

endpackage

//--- verilog/bitWindow.sv
`timescale 1ns/1ps

module bitWindow
    import firPkg::*;
(
    input  logic                clkDS,
    input  logic                rst,
    input  logic                bitIn,
    output logic [tapCount-1:0] window,
    output logic                windowValid
);

    // older bits, history[0] is the bit taken on the previous edge.
    logic [tapCount-2:0] history;

    // taps[a] is the bit of age a when the current edge captures.
    logic [tapCount-1:0] taps;
    logic [tapCount-1:0] ordered;

    logic [$clog2(osrFactor)-1:0] phase;
    logic capture;

    assign taps = {history, bitIn};
    assign capture = (phase == osrFactor - 1);

    // lookahead half is reversed so bit k meets coefAhead[k].
    always_comb begin
        ordered = taps;
        for (int k = 0; k < lookahead; k++) begin
            ordered[k] = taps[lookahead-1-k];
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            history <= '0;
            phase <= '0;
            windowValid <= 1'b0;
        end else begin
            history <= taps[tapCount-2:0];
            windowValid <= capture;
            if (capture) begin
                phase <= '0;
            end else begin
                phase <= phase + 1'b1;
            end
        end
    end

    // window is only read while windowValid is high.
    always_ff @(posedge clkDS) begin
        if (capture) begin
            window <= ordered;
        end
    end

    // captures are osrFactor bits apart, never back to back.
    assert property (@(posedge clkDS) disable iff (!rst)
        windowValid |=> !windowValid)
        else $error("windowValid high on consecutive cycles");

endmodule

//--- verilog/lutStage.sv
`timescale 1ns/1ps

module lutStage
    import firPkg::*;
(
    input  logic                               clkDS,
    input  logic                               rst,
    input  logic [tapCount-1:0]                window,
    input  logic                               windowValid,
    output logic [lutCount-1:0][partWidth-1:0] partSums,
    output logic                               partValid
);

    logic [lutCount-1:0][lutSize-1:0] addr;
    logic [lutCount-1:0][partWidth-1:0] lookup;

    // each group of lutSize window bits addresses its own table.
    always_comb begin
        for (int g = 0; g < lutCount; g++) begin
            addr[g] = window[g*lutSize +: lutSize];
            lookup[g] = lutTables[g][addr[g]];
        end
    end

    always_ff @(posedge clkDS) begin
        if (windowValid) begin
            partSums <= lookup;
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            partValid <= 1'b0;
        end else begin
            partValid <= windowValid;
        end
    end

    // partial sums trail the window by exactly one cycle.
    assert property (@(posedge clkDS) disable iff (!rst)
        windowValid |=> partValid)
        else $error("partValid missing after windowValid");

    assert property (@(posedge clkDS) disable iff (!rst)
        partValid |-> $past(windowValid))
        else $error("partValid without windowValid one cycle earlier");

endmodule

//--- verilog/adderTree.sv
`timescale 1ns/1ps

module adderTree
    import firPkg::*;
(
    input  logic                               clkDS,
    input  logic                               rst,
    input  logic [lutCount-1:0][partWidth-1:0] partSums,
    input  logic                               partValid,
    output logic signed [sumWidth-1:0]         sampleOut,
    output logic                               sampleValid
);

    logic signed [partWidth-1:0] partA;
    logic signed [partWidth-1:0] partB;
    logic signed [partWidth-1:0] partC;
    logic signed [partWidth-1:0] partD;

    // first level, one pair per half of the window.
    logic signed [partWidth:0] pairLo;
    logic signed [partWidth:0] pairHi;

    // second level.
    logic signed [sumWidth-1:0] total;

    // validPipe[i] marks the data held in level i+1.
    logic [2:0] validPipe;

    assign partA = $signed(partSums[0]);
    assign partB = $signed(partSums[1]);
    assign partC = $signed(partSums[2]);
    assign partD = $signed(partSums[3]);

    always_ff @(posedge clkDS) begin
        if (partValid) begin
            pairLo <= partA + partB;
            pairHi <= partC + partD;
        end
    end

    always_ff @(posedge clkDS) begin
        if (validPipe[0]) begin
            total <= pairLo + pairHi;
        end
    end

    // output register holds the last sample between pulses.
    always_ff @(posedge clkDS) begin
        if (!rst) begin
            sampleOut <= '0;
        end else if (validPipe[1]) begin
            sampleOut <= total;
        end
    end

    always_ff @(posedge clkDS) begin
        if (!rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[1:0], partValid};
        end
    end

    assign sampleValid = validPipe[2];

    // every sample leaves the tree three cycles after its partial sums.
    assert property (@(posedge clkDS) disable iff (!rst)
        sampleValid |-> $past(partValid, 3))
        else $error("sampleValid without partValid three cycles earlier");

endmodule

//--- verilog/firDecimator.sv
`timescale 1ns/1ps

module firDecimator
    import firPkg::*;
(
    input  logic                       clkDS,
    input  logic                       rst,
    input  logic                       bitIn,
    output logic signed [sumWidth-1:0] sampleOut,
    output logic                       sampleValid
);

    logic [tapCount-1:0] window;
    logic windowValid;

    logic [lutCount-1:0][partWidth-1:0] partSums;
    logic partValid;

    // bit window capture, once every osrFactor bits.
    bitWindow bitWindow_i (
        .clkDS       (clkDS),
        .rst         (rst),
        .bitIn       (bitIn),
        .window      (window),
        .windowValid (windowValid)
    );

    // table lookups, holding the partial sums for the tree.
    lutStage lutStage_i (
        .clkDS       (clkDS),
        .rst         (rst),
        .window      (window),
        .windowValid (windowValid),
        .partSums    (partSums),
        .partValid   (partValid)
    );

    adderTree adderTree_i (
        .clkDS       (clkDS),
        .rst         (rst),
        .partSums    (partSums),
        .partValid   (partValid),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid)
    );

endmodule

//--- include/firTbTasks.svh
`ifndef firTbTasksSvh
`define firTbTasksSvh

// compares one output sample against its expected value.
task automatic checkSample(
    input logic signed [sumWidth-1:0] got,
    input logic signed [sumWidth-1:0] expected,
    input string what,
    input int testId
);
    checkCount[testId]++;
    if (got !== expected) begin
        errorCount[testId]++;
        $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
    end
endtask

// compares one level such as sampleValid.
task automatic checkFlag(
    input logic got,
    input logic expected,
    input string what,
    input int testId
);
    checkCount[testId]++;
    if (got !== expected) begin
        errorCount[testId]++;
        $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, expected);
    end
endtask

// linear congruential step, the top bit is used as stimulus.
function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

`endif

//--- sim/firDecimatorTb.sv
`timescale 1ns/1ps

module firDecimatorTb
    import firPkg::*;
();

    localparam int resetCycles = 8;
    localparam int randomBits = 200;
    localparam int firstSampleEdge = osrFactor + 5;
    localparam logic [31:0] seed = 32'h1242db31;
    localparam int testReset = 0;
    localparam int testDirected = 1;
    localparam int testSpacing = 2;
    localparam int testRandom = 3;

    logic clkDS;
    logic rst;
    logic bitIn;
    logic signed [sumWidth-1:0] sampleOut;
    logic sampleValid;

    int checkCount [4];
    int errorCount [4];
    bit dirBits [$];
    bit driven [$];
    logic signed [sumWidth-1:0] expQueue [$];
    int dirCount;
    int totalExpected;
    int samplesSeen;
    int watchLimit;

    `include "firTbTasks.svh"

    firDecimator firDecimator_i (
        .clkDS       (clkDS),
        .rst         (rst),
        .bitIn       (bitIn),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid)
    );

    initial begin : clockGen
        clkDS = 1'b0;
        forever #2 clkDS = ~clkDS;
    end

    // weight of the tap with the given age, age 0 being the newest bit.
    function automatic int ruleWeight(input int age);
        if (age < lookahead) begin
            return int'(coefAhead[lookahead - 1 - age]);
        end
        return int'(coefBack[age - lookahead]);
    endfunction

    // filter output over the bits driven so far.
    function automatic logic signed [sumWidth-1:0] modelSample();
        int acc;
        int newest;
        acc = 0;
        newest = driven.size() - 1;
        for (int a = 0; a < tapCount; a++) begin
            if (newest - a >= 0) begin
                if (driven[newest - a]) begin
                    acc += ruleWeight(a);
                end
            end
        end
        return acc[sumWidth-1:0];
    endfunction

    task automatic loadVectors();
        int fd;
        int code;
        int value;
        string line;
        logic [sumWidth-1:0] sampleWord;
        fd = $fopen("sim/firVectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open sim/firVectors.txt, no directed vectors were run");
            errorCount[testDirected]++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 2 && line.getc(0) == "B") begin
                code = $sscanf(line.substr(2, line.len() - 1), "%h", value);
                dirBits.push_back(value[0]);
            end else if (code > 2 && line.getc(0) == "E") begin
                code = $sscanf(line.substr(2, line.len() - 1), "%h", sampleWord);
                expQueue.push_back(sampleWord);
            end
        end
        $fclose(fd);
        if (dirBits.size() % osrFactor != 0 || expQueue.size() != dirBits.size() / osrFactor) begin
            $display("Vectors file holds %0d bits but %0d expected samples, they do not match",
                dirBits.size(), expQueue.size());
            errorCount[testDirected]++;
        end
    endtask

    // drives one bit and queues the model value when this bit completes a capture.
    task automatic driveBit(input bit value, input bit queueModel);
        bitIn <= value;
        driven.push_back(value);
        if (queueModel && driven.size() % osrFactor == 0) begin
            expQueue.push_back(modelSample());
        end
        @(posedge clkDS);
    endtask

    task automatic reportTest(input int testId, input string name);
        $display("%s: %0d checks, %0d errors, %s", name, checkCount[testId],
            errorCount[testId], errorCount[testId] == 0 ? "ok" : "FAILED");
    endtask

    initial begin : mainSequence
        logic [31:0] state;
        int checks;
        int errors;
        rst = 1'b0;
        bitIn = 1'b0;
        checks = 0;
        errors = 0;
        loadVectors();
        dirCount = expQueue.size();
        totalExpected = dirCount + randomBits / osrFactor;
        watchLimit = (dirBits.size() + randomBits) * 20 + 100;
        for (int c = 1; c <= resetCycles; c++) begin
            @(posedge clkDS);
            // registers are unknown until the first reset edge.
            if (c > 1) begin
                checkFlag(sampleValid, 1'b0, "sampleValid in reset", testReset);
                checkSample(sampleOut, '0, "sampleOut in reset", testReset);
            end
        end
        rst <= 1'b1;
        foreach (dirBits[k]) begin
            driveBit(dirBits[k], 1'b0);
        end
        state = seed;
        for (int n = 0; n < randomBits; n++) begin
            state = nextRandom(state);
            driveBit(state[31], 1'b1);
        end
        bitIn <= 1'b0;
        while (samplesSeen < totalExpected) begin
            @(posedge clkDS);
        end
        reportTest(testSpacing, "sample spacing");
        reportTest(testRandom, "random stream");
        for (int t = 0; t < 4; t++) begin
            checks += checkCount[t];
            errors += errorCount[t];
        end
        $display("4 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : sampleMonitor
        int edgeCount;
        int gap;
        int testId;
        bit seenValid;
        logic signed [sumWidth-1:0] expected;
        edgeCount = 0;
        gap = 0;
        seenValid = 1'b0;
        forever begin
            @(posedge clkDS);
            if (rst) begin
                edgeCount++;
                if (!seenValid) begin
                    checkFlag(sampleValid, edgeCount == firstSampleEdge, "first sampleValid",
                        testReset);
                    if (!sampleValid) begin
                        checkSample(sampleOut, '0, "sampleOut before first sample", testReset);
                    end
                end else if (samplesSeen < totalExpected) begin
                    gap++;
                    checkFlag(sampleValid, gap == osrFactor, "sampleValid spacing", testSpacing);
                end
                if (sampleValid) begin
                    if (!seenValid) begin
                        seenValid = 1'b1;
                        reportTest(testReset, "reset");
                    end
                    gap = 0;
                    if (samplesSeen < totalExpected) begin
                        testId = (samplesSeen < dirCount) ? testDirected : testRandom;
                        if (expQueue.size() == 0) begin
                            $display("Sample %0d arrived with no expected value queued",
                                samplesSeen);
                            errorCount[testId]++;
                        end else begin
                            expected = expQueue.pop_front();
                            checkSample(sampleOut, expected,
                                $sformatf("sample %0d", samplesSeen), testId);
                        end
                        samplesSeen++;
                        if (samplesSeen == dirCount) begin
                            reportTest(testDirected, "directed vectors");
                        end
                    end
                end
            end
        end
    end

    // ends a run whose samples stop arriving.
    initial begin : watchdog
        wait (watchLimit > 0);
        repeat (watchLimit) @(posedge clkDS);
        $display("Timeout after %0d cycles, the DUT stopped producing samples", watchLimit);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- sim/firVectors.txt
# B <bit> drives one stimulus bit into bitIn
# E <hex> gives the next expected sampleOut in 21-bit two's complement
# single 1 bit as the newest tap of the first capture, then zeros
B 0
B 0
B 0
B 1
E 1fff88
B 0
B 0
B 0
B 0
E 0002b2
B 0
B 0
B 0
B 0
E 001e96
B 0
B 0
B 0
B 0
E 00263e
B 0
B 0
B 0
B 0
E 00161c
B 0
B 0
B 0
B 0
E 1fff42
B 0
B 0
B 0
B 0
E 000000
# all ones until every tap is set
B 1
B 1
B 1
B 1
E 1ffc24
B 1
B 1
B 1
B 1
E 002e60
B 1
B 1
B 1
B 1
E 00bcfe
B 1
B 1
B 1
B 1
E 01487c
B 1
B 1
B 1
B 1
E 0176da
B 1
B 1
B 1
B 1
E 017306

//--- firDecimator.f
+incdir+include
verilog/firPkg.sv
verilog/bitWindow.sv
verilog/lutStage.sv
verilog/adderTree.sv
verilog/firDecimator.sv
sim/firDecimatorTb.sv

//--- runSim.sh
#!/bin/sh
# Build with Verilator, run the testbench into sim.log and look for the pass message.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f firDecimator.f \
    --top-module firDecimatorTb -o firDecimatorSim \
    && ./obj_dir/firDecimatorSim > sim.log 2>&1 \
    || echo "build or simulation run returned an error"
[ -f sim.log ] && cat sim.log
grep -q "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
